// File: sim/flow_patterns.txt
// op[63:60] a[59:56] b[55:52] unused[51:48] value[47:0], one record per line
// op 1 write a=reg value=data, 2 read a=reg value=expected, 3 header a=port b=hit value=mac
// op 4 same on all ports with mac+port, op 5 counters against prediction, op 0 end
3_0_0_0_001122334455
3_0_0_0_0a0b0c0d0e0f
4_0_0_0_020000000010
5_0_0_0_000000000000
2_9_0_0_000000000006
1_0_0_0_000000000000
1_1_0_0_000022334455
1_2_0_0_000000000011
1_3_0_0_0000ffffffff
1_4_0_0_00000000ffff
1_5_0_0_000000000006
2_5_0_0_000000000006
1_6_0_0_000000000000
3_0_0_0_001122334455
1_7_0_0_000000000000
2_a_0_0_000000000001
3_2_1_0_001122334455
1_0_0_0_000000000001
1_1_0_0_0000ccdd0000
1_2_0_0_00000000aabb
1_3_0_0_0000ffff0000
1_5_0_0_000000000007
1_6_0_0_000000000000
1_0_0_0_000000000002
1_1_0_0_0000ccdd1234
1_3_0_0_0000ffffffff
1_5_0_0_000000000005
1_6_0_0_000000000000
1_7_0_0_000000000000
2_a_0_0_000000000000
3_3_1_0_aabbccdd1234
3_3_1_0_aabbccdd9999
3_0_0_0_001122334455
4_3_1_0_aabbccdd0100
4_0_0_0_020000000020
5_0_0_0_000000000000
1_8_0_0_000000000000
2_8_0_0_000000000000
2_9_0_0_000000000000
5_0_0_0_000000000000
0_0_0_0_000000000000

// File: files.f
common/flow_cfg_pkg.sv
common/flow_types_pkg.sv
verilog/input_header_arbiter.sv
flow_table/mac_match_table.sv
flow_table/flow_table_controller.sv
verilog/output_action_arbiter.sv
verilog/flow_table_processor.sv
sim/flow_table_processor_assertions.sv
sim/tb_flow_table_processor.sv

// File: sim/tb_flow_table_processor.sv
// testbench for the flow table processor that replays the pattern file over streams and registers
`timescale 1ns/1ps
`default_nettype none

module tb_flow_table_processor;

   localparam int max_records       = 64;
   localparam int cycles_per_record = 200;
   localparam int np                = flow_cfg_pkg::num_ports;

   logic                                   axi_aclk;
   logic                                   axi_resetn;
   flow_types_pkg::hdr_t [np-1:0]          s_hdr;
   logic [np-1:0]                          s_valid;
   logic [np-1:0]                          s_ready;
   flow_types_pkg::act_t [np-1:0]          m_act;
   logic [np-1:0]                          m_valid;
   logic [np-1:0]                          m_ready;
   logic                                   wb_cyc;
   logic                                   wb_stb;
   logic                                   wb_we;
   logic [flow_cfg_pkg::wb_addr_width-1:0] wb_adr;
   logic [flow_cfg_pkg::wb_data_width-1:0] wb_dat_w;
   logic [flow_cfg_pkg::wb_data_width-1:0] wb_dat_r;
   logic                                   wb_ack;

   // op[63:60] a[59:56] b[55:52] value[47:0]
   logic [63:0]                            records [max_records];
   logic [63:0]                            rec;
   int                                     n_records;
   int                                     cycle_limit;
   int                                     cycle_count;
   int                                     errors;
   int                                     err_before;
   int                                     tests_run;
   int                                     tests_failed;
   int                                     pred_hit;
   int                                     pred_miss;
   int                                     assert_fails;
   logic [31:0]                            stall_state;
   logic [31:0]                            port_state;
   flow_types_pkg::act_t                   got_act[$];
   logic [flow_cfg_pkg::port_idx_width-1:0] got_port[$];

   flow_table_processor i_flow_table_processor (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic check_act(input string name, input flow_types_pkg::act_t got,
                            input flow_types_pkg::act_t exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_port(input string name,
                             input logic [flow_cfg_pkg::port_idx_width-1:0] got,
                             input logic [flow_cfg_pkg::port_idx_width-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_reg(input string name,
                            input logic [flow_cfg_pkg::wb_data_width-1:0] got,
                            input logic [flow_cfg_pkg::wb_data_width-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // one classic cycle that returns once the ack has been seen
   task automatic wb_access(input logic we, input logic [flow_cfg_pkg::wb_addr_width-1:0] adr,
                            input logic [flow_cfg_pkg::wb_data_width-1:0] dat,
                            output logic [flow_cfg_pkg::wb_data_width-1:0] rdat);
      @(posedge axi_aclk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= dat;
      @(posedge axi_aclk);
      while (!wb_ack) @(posedge axi_aclk);
      rdat = wb_dat_r;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic send_hdr(input int p, input logic [flow_cfg_pkg::mac_width-1:0] mac);
      flow_types_pkg::hdr_t h;
      h.dst_mac  = mac;
      // the arbiter replaces this sender value with the grant
      h.src_port = 2'(p + 1);
      @(posedge axi_aclk);
      s_hdr[p]   <= h;
      s_valid[p] <= 1'b1;
      @(posedge axi_aclk);
      while (!s_ready[p]) @(posedge axi_aclk);
      s_valid[p] <= 1'b0;
   endtask

   task automatic run_header(input logic [63:0] r);
      int                   p;
      flow_types_pkg::act_t exp;
      p = port_state[29:28];
      port_state = lcg_next(port_state);
      got_act.delete();
      got_port.delete();
      send_hdr(p, r[47:0]);
      while (got_act.size() < 1) @(posedge axi_aclk);
      exp.hit      = r[52];
      exp.miss     = !r[52];
      exp.src_port = 2'(p);
      exp.dst_mac  = r[47:0];
      check_port("egress port", got_port[0], r[57:56]);
      check_act("m_act", got_act[0], exp);
      if (r[52]) pred_hit++;
      else pred_miss++;
   endtask

   // all ports at once and each must come out exactly once
   task automatic run_burst(input logic [63:0] r);
      int                   found;
      int                   idx;
      flow_types_pkg::act_t exp;
      got_act.delete();
      got_port.delete();
      fork
         send_hdr(0, r[47:0] + 48'd0);
         send_hdr(1, r[47:0] + 48'd1);
         send_hdr(2, r[47:0] + 48'd2);
         send_hdr(3, r[47:0] + 48'd3);
      join
      while (got_act.size() < np) @(posedge axi_aclk);
      for (int p = 0; p < np; p++) begin
         found = 0;
         idx   = 0;
         for (int k = 0; k < got_act.size(); k++) begin
            if (got_act[k].src_port == p) begin
               found++;
               idx = k;
            end
         end
         exp.hit      = r[52];
         exp.miss     = !r[52];
         exp.src_port = 2'(p);
         exp.dst_mac  = r[47:0] + 48'(p);
         if (found != 1) begin
            errors++;
            $display("header from port %0d arrived %0d times instead of once", p, found);
         end else begin
            check_port("egress port", got_port[idx], r[57:56]);
            check_act("m_act", got_act[idx], exp);
         end
         if (r[52]) pred_hit++;
         else pred_miss++;
      end
   endtask

   task automatic run_counters();
      logic [flow_cfg_pkg::wb_data_width-1:0] rd;
      wb_access(1'b0, flow_cfg_pkg::reg_hit_count, '0, rd);
      check_reg("hit_count", rd, pred_hit);
      wb_access(1'b0, flow_cfg_pkg::reg_miss_count, '0, rd);
      check_reg("miss_count", rd, pred_miss);
   endtask

   // egress stalls on about one cycle in four per port
   always @(posedge axi_aclk) begin
      stall_state <= lcg_next(stall_state);
      for (int p = 0; p < np; p++) begin
         m_ready[p] <= stall_state[24 + 2*p +: 2] != 2'b00;
      end
   end

   always @(posedge axi_aclk) begin
      for (int p = 0; p < np; p++) begin
         if (m_valid[p] && m_ready[p]) begin
            got_act.push_back(m_act[p]);
            got_port.push_back(2'(p));
         end
      end
   end

   initial begin
      axi_aclk = 1'b0;
      forever #2 axi_aclk = ~axi_aclk;
   end

   initial begin
      cycle_count = 0;
      @(posedge axi_aclk);
      while (cycle_count < cycle_limit) begin
         @(posedge axi_aclk);
         cycle_count++;
      end
      $display("timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
   end

   initial begin
      logic [flow_cfg_pkg::wb_data_width-1:0] rd;
      axi_resetn   = 1'b0;
      s_hdr        = '0;
      s_valid      = '0;
      m_ready      = '1;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      stall_state  = 32'd34;
      port_state   = 32'd34;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      pred_hit     = 0;
      pred_miss    = 0;
      $readmemh("sim/flow_patterns.txt", records);
      n_records = 0;
      while (n_records < max_records && records[n_records][63:60] >= 4'h1 &&
             records[n_records][63:60] <= 4'h5) begin
         n_records++;
      end
      cycle_limit = cycles_per_record * (n_records + 1);
      if (n_records == 0) begin
         errors++;
         $display("no pattern records could be read from sim/flow_patterns.txt");
      end
      repeat (4) @(posedge axi_aclk);
      axi_resetn <= 1'b1;
      for (int r = 0; r < n_records; r++) begin
         rec        = records[r];
         err_before = errors;
         case (rec[63:60])
            4'h1: begin
               wb_access(1'b1, rec[59:56], rec[31:0], rd);
               if (rec[59:56] == flow_cfg_pkg::reg_hit_count ||
                   rec[59:56] == flow_cfg_pkg::reg_miss_count) begin
                  pred_hit  = 0;
                  pred_miss = 0;
               end
            end
            4'h2: begin
               wb_access(1'b0, rec[59:56], '0, rd);
               check_reg($sformatf("register %0d", rec[59:56]), rd, rec[31:0]);
            end
            4'h3: run_header(rec);
            4'h4: run_burst(rec);
            default: run_counters();
         endcase
         if (rec[63:60] != 4'h1) begin
            tests_run++;
            if (errors != err_before) tests_failed++;
            $display("test %0d, record %0d, op %0d: %s", tests_run, r, rec[63:60],
                     errors == err_before ? "ok" : "failed");
         end
      end
      assert_fails = i_flow_table_processor.i_flow_table_processor_assertions.fail_count;
      if (assert_fails != 0) begin
         errors += assert_fails;
         $display("handshake assertions failed %0d times", assert_fails);
      end
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_run - tests_failed, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/flow_table_processor_assertions.sv
// handshake checks on the flow table processor streams and register bus
`timescale 1ns/1ps
`default_nettype none

module flow_table_processor_assertions (
   input  wire logic                                          axi_aclk,
   input  wire logic                                          axi_resetn,
   input  wire flow_types_pkg::hdr_t [flow_cfg_pkg::num_ports-1:0] s_hdr,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            s_valid,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            s_ready,
   input  wire flow_types_pkg::act_t [flow_cfg_pkg::num_ports-1:0] m_act,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            m_valid,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            m_ready,
   input  wire logic                                          wb_cyc,
   input  wire logic                                          wb_stb,
   input  wire logic                                          wb_ack
);

   // number of failed assertions
   int fail_count = 0;

   // valid holds with stable data until the transfer
   for (genvar p = 0; p < flow_cfg_pkg::num_ports; p++) begin : g_port
      in_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
         s_valid[p] && !s_ready[p] |=> s_valid[p] && $stable(s_hdr[p]))
         else begin
            fail_count++;
            $error("ingress port %0d changed before ready", p);
         end
      out_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
         m_valid[p] && !m_ready[p] |=> m_valid[p] && $stable(m_act[p]))
         else begin
            fail_count++;
            $error("egress port %0d changed before ready", p);
         end
   end

   ack_one_cycle: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      wb_ack |=> !wb_ack)
      else begin
         fail_count++;
         $error("wb_ack high for more than one cycle");
      end

   ack_after_stb: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      wb_ack |-> $past(wb_cyc && wb_stb))
      else begin
         fail_count++;
         $error("wb_ack without a preceding strobe");
      end

endmodule

bind flow_table_processor flow_table_processor_assertions i_flow_table_processor_assertions (.*);

`default_nettype wire

// File: verilog/flow_table_processor.sv
// flow table processor top that merges ingress headers, looks them up and steers actions
`timescale 1ns/1ps
`default_nettype none

module flow_table_processor (
   input  wire logic                                          axi_aclk,
   input  wire logic                                          axi_resetn,
   input  wire flow_types_pkg::hdr_t [flow_cfg_pkg::num_ports-1:0] s_hdr,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            s_valid,
   output      logic [flow_cfg_pkg::num_ports-1:0]            s_ready,
   output flow_types_pkg::act_t [flow_cfg_pkg::num_ports-1:0] m_act,
   output      logic [flow_cfg_pkg::num_ports-1:0]            m_valid,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            m_ready,
   input  wire logic                                          wb_cyc,
   input  wire logic                                          wb_stb,
   input  wire logic                                          wb_we,
   input  wire logic [flow_cfg_pkg::wb_addr_width-1:0]        wb_adr,
   input  wire logic [flow_cfg_pkg::wb_data_width-1:0]        wb_dat_w,
   output      logic [flow_cfg_pkg::wb_data_width-1:0]        wb_dat_r,
   output      logic                                          wb_ack
);

   flow_types_pkg::hdr_t       arb_hdr;
   logic                       arb_valid;
   logic                       arb_ready;
   flow_types_pkg::lookup_t    lkp;
   logic                       lkp_valid;
   logic                       lkp_ready;
   flow_types_pkg::tbl_entry_t tbl_wr_entry;
   logic [flow_cfg_pkg::tbl_addr_width-1:0] tbl_wr_idx;
   logic                       tbl_wr_en;
   logic                       bank_swap;
   logic                       hit_pulse;
   logic                       miss_pulse;
   logic                       active_bank;

   input_header_arbiter i_input_header_arbiter (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .s_hdr      (s_hdr),
      .s_valid    (s_valid),
      .s_ready    (s_ready),
      .arb_hdr    (arb_hdr),
      .arb_valid  (arb_valid),
      .arb_ready  (arb_ready)
   );

   mac_match_table i_mac_match_table (
      .axi_aclk     (axi_aclk),
      .axi_resetn   (axi_resetn),
      .arb_hdr      (arb_hdr),
      .arb_valid    (arb_valid),
      .arb_ready    (arb_ready),
      .lkp          (lkp),
      .lkp_valid    (lkp_valid),
      .lkp_ready    (lkp_ready),
      .tbl_wr_en    (tbl_wr_en),
      .tbl_wr_idx   (tbl_wr_idx),
      .tbl_wr_entry (tbl_wr_entry),
      .bank_swap    (bank_swap),
      .hit_pulse    (hit_pulse),
      .miss_pulse   (miss_pulse),
      .active_bank  (active_bank)
   );

   flow_table_controller i_flow_table_controller (
      .axi_aclk     (axi_aclk),
      .axi_resetn   (axi_resetn),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .tbl_wr_en    (tbl_wr_en),
      .tbl_wr_idx   (tbl_wr_idx),
      .tbl_wr_entry (tbl_wr_entry),
      .bank_swap    (bank_swap),
      .hit_pulse    (hit_pulse),
      .miss_pulse   (miss_pulse),
      .active_bank  (active_bank)
   );

   output_action_arbiter i_output_action_arbiter (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .lkp        (lkp),
      .lkp_valid  (lkp_valid),
      .lkp_ready  (lkp_ready),
      .m_act      (m_act),
      .m_valid    (m_valid),
      .m_ready    (m_ready)
   );

endmodule

`default_nettype wire

// File: verilog/output_action_arbiter.sv
// per-port output registers steering each lookup result to its egress queue
`timescale 1ns/1ps
`default_nettype none

module output_action_arbiter (
   input  wire logic                                          axi_aclk,
   input  wire logic                                          axi_resetn,
   input  wire flow_types_pkg::lookup_t                       lkp,
   input  wire logic                                          lkp_valid,
   output      logic                                          lkp_ready,
   output flow_types_pkg::act_t [flow_cfg_pkg::num_ports-1:0] m_act,
   output      logic [flow_cfg_pkg::num_ports-1:0]            m_valid,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            m_ready
);

   logic load;

   // a busy target port stalls the whole pipeline
   assign lkp_ready = !m_valid[lkp.dst_port] || m_ready[lkp.dst_port];
   assign load      = lkp_valid && lkp_ready;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         m_valid <= '0;
      end else begin
         for (int p = 0; p < flow_cfg_pkg::num_ports; p++) begin
            if (load && lkp.dst_port == p) begin
               m_valid[p] <= 1'b1;
            end else if (m_ready[p]) begin
               m_valid[p] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (load) begin
         m_act[lkp.dst_port].hit      <= lkp.hit;
         m_act[lkp.dst_port].miss     <= !lkp.hit;
         m_act[lkp.dst_port].src_port <= lkp.src_port;
         m_act[lkp.dst_port].dst_mac  <= lkp.dst_mac;
      end
   end

endmodule

`default_nettype wire

// File: flow_table/flow_table_controller.sv
// wishbone register block for entry staging, bank swap and lookup counters
`timescale 1ns/1ps
`default_nettype none

module flow_table_controller (
   input  wire logic                                    axi_aclk,
   input  wire logic                                    axi_resetn,
   input  wire logic                                    wb_cyc,
   input  wire logic                                    wb_stb,
   input  wire logic                                    wb_we,
   input  wire logic [flow_cfg_pkg::wb_addr_width-1:0]  wb_adr,
   input  wire logic [flow_cfg_pkg::wb_data_width-1:0]  wb_dat_w,
   output      logic [flow_cfg_pkg::wb_data_width-1:0]  wb_dat_r,
   output      logic                                    wb_ack,
   output      logic                                    tbl_wr_en,
   output      logic [flow_cfg_pkg::tbl_addr_width-1:0] tbl_wr_idx,
   output flow_types_pkg::tbl_entry_t                   tbl_wr_entry,
   output      logic                                    bank_swap,
   input  wire logic                                    hit_pulse,
   input  wire logic                                    miss_pulse,
   input  wire logic                                    active_bank
);

   logic                                   access;
   logic                                   wr;
   logic                                   cnt_clr;
   logic [flow_cfg_pkg::wb_data_width-1:0] hit_count;
   logic [flow_cfg_pkg::wb_data_width-1:0] miss_count;

   // one access per strobe, ack follows one cycle later
   assign access  = wb_cyc && wb_stb && !wb_ack;
   assign wr      = access && wb_we;
   assign cnt_clr = wr && (wb_adr == flow_cfg_pkg::reg_hit_count ||
                           wb_adr == flow_cfg_pkg::reg_miss_count);

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wb_ack     <= 1'b0;
         tbl_wr_en  <= 1'b0;
         bank_swap  <= 1'b0;
         hit_count  <= '0;
         miss_count <= '0;
      end else begin
         wb_ack    <= access;
         tbl_wr_en <= wr && wb_adr == flow_cfg_pkg::reg_commit;
         bank_swap <= wr && wb_adr == flow_cfg_pkg::reg_swap;
         if (cnt_clr) begin
            hit_count  <= '0;
            miss_count <= '0;
         end else begin
            hit_count  <= hit_count + hit_pulse;
            miss_count <= miss_count + miss_pulse;
         end
      end
   end

   // staged entry, handed to the table on commit
   always_ff @(posedge axi_aclk) begin
      if (wr) begin
         case (wb_adr)
            flow_cfg_pkg::reg_entry_idx: tbl_wr_idx <= wb_dat_w[flow_cfg_pkg::tbl_addr_width-1:0];
            flow_cfg_pkg::reg_key_lo:    tbl_wr_entry.key[31:0]   <= wb_dat_w;
            flow_cfg_pkg::reg_key_hi:    tbl_wr_entry.key[47:32]  <= wb_dat_w[15:0];
            flow_cfg_pkg::reg_mask_lo:   tbl_wr_entry.mask[31:0]  <= wb_dat_w;
            flow_cfg_pkg::reg_mask_hi:   tbl_wr_entry.mask[47:32] <= wb_dat_w[15:0];
            flow_cfg_pkg::reg_action: begin
               tbl_wr_entry.port  <= wb_dat_w[1:0];
               tbl_wr_entry.valid <= wb_dat_w[2];
            end
            default: ;
         endcase
      end
   end

   // read data is held for the ack cycle
   always_ff @(posedge axi_aclk) begin
      if (access) begin
         case (wb_adr)
            flow_cfg_pkg::reg_entry_idx:  wb_dat_r <= {29'd0, tbl_wr_idx};
            flow_cfg_pkg::reg_key_lo:     wb_dat_r <= tbl_wr_entry.key[31:0];
            flow_cfg_pkg::reg_key_hi:     wb_dat_r <= {16'd0, tbl_wr_entry.key[47:32]};
            flow_cfg_pkg::reg_mask_lo:    wb_dat_r <= tbl_wr_entry.mask[31:0];
            flow_cfg_pkg::reg_mask_hi:    wb_dat_r <= {16'd0, tbl_wr_entry.mask[47:32]};
            flow_cfg_pkg::reg_action:     wb_dat_r <= {29'd0, tbl_wr_entry.valid, tbl_wr_entry.port};
            flow_cfg_pkg::reg_hit_count:  wb_dat_r <= hit_count;
            flow_cfg_pkg::reg_miss_count: wb_dat_r <= miss_count;
            flow_cfg_pkg::reg_status:     wb_dat_r <= {31'd0, active_bank};
            default:                      wb_dat_r <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: flow_table/mac_match_table.sv
// double-buffered ternary destination MAC table with a registered lookup stage
`timescale 1ns/1ps
`default_nettype none

module mac_match_table (
   input  wire logic                                    axi_aclk,
   input  wire logic                                    axi_resetn,
   input  wire flow_types_pkg::hdr_t                    arb_hdr,
   input  wire logic                                    arb_valid,
   output      logic                                    arb_ready,
   output flow_types_pkg::lookup_t                      lkp,
   output      logic                                    lkp_valid,
   input  wire logic                                    lkp_ready,
   input  wire logic                                    tbl_wr_en,
   input  wire logic [flow_cfg_pkg::tbl_addr_width-1:0] tbl_wr_idx,
   input  wire flow_types_pkg::tbl_entry_t              tbl_wr_entry,
   input  wire logic                                    bank_swap,
   output      logic                                    hit_pulse,
   output      logic                                    miss_pulse,
   output      logic                                    active_bank
);

   // two banks whose entry valid bits live apart and clear on reset
   flow_types_pkg::tbl_entry_t bank_mem [2][flow_cfg_pkg::tbl_depth];
   logic [1:0][flow_cfg_pkg::tbl_depth-1:0] ent_valid;

   logic                                    take;
   logic                                    found;
   logic [flow_cfg_pkg::port_idx_width-1:0] match_port;

   assign take      = !lkp_valid || lkp_ready;
   assign arb_ready = take;

   // lowest matching index wins
   always_comb begin
      found      = 1'b0;
      match_port = '0;
      for (int i = 0; i < flow_cfg_pkg::tbl_depth; i++) begin
         if (!found && ent_valid[active_bank][i] &&
             (((arb_hdr.dst_mac ^ bank_mem[active_bank][i].key) &
               bank_mem[active_bank][i].mask) == '0)) begin
            found      = 1'b1;
            match_port = bank_mem[active_bank][i].port;
         end
      end
   end

   // software only ever writes the shadow bank
   always_ff @(posedge axi_aclk) begin
      if (tbl_wr_en) begin
         bank_mem[!active_bank][tbl_wr_idx] <= tbl_wr_entry;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         ent_valid   <= '0;
         active_bank <= 1'b0;
      end else begin
         if (tbl_wr_en) begin
            ent_valid[!active_bank][tbl_wr_idx] <= tbl_wr_entry.valid;
         end
         if (bank_swap) begin
            active_bank <= !active_bank;
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         lkp_valid  <= 1'b0;
         hit_pulse  <= 1'b0;
         miss_pulse <= 1'b0;
      end else begin
         hit_pulse  <= take && arb_valid && found;
         miss_pulse <= take && arb_valid && !found;
         if (take) begin
            lkp_valid <= arb_valid;
         end
      end
   end

   // a miss goes to the host port
   always_ff @(posedge axi_aclk) begin
      if (take && arb_valid) begin
         lkp.dst_mac  <= arb_hdr.dst_mac;
         lkp.src_port <= arb_hdr.src_port;
         lkp.hit      <= found;
         lkp.dst_port <= found ? match_port : '0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/input_header_arbiter.sv
// round-robin arbiter merging the ingress header streams into one registered stream
`timescale 1ns/1ps
`default_nettype none

module input_header_arbiter (
   input  wire logic                                          axi_aclk,
   input  wire logic                                          axi_resetn,
   input  wire flow_types_pkg::hdr_t [flow_cfg_pkg::num_ports-1:0] s_hdr,
   input  wire logic [flow_cfg_pkg::num_ports-1:0]            s_valid,
   output      logic [flow_cfg_pkg::num_ports-1:0]            s_ready,
   output flow_types_pkg::hdr_t                               arb_hdr,
   output      logic                                          arb_valid,
   input  wire logic                                          arb_ready
);

   logic                                    take;
   logic                                    grant_any;
   logic [flow_cfg_pkg::port_idx_width-1:0] grant_idx;
   logic [flow_cfg_pkg::port_idx_width-1:0] last_grant;
   logic [flow_cfg_pkg::port_idx_width-1:0] cand;
   logic [flow_cfg_pkg::num_ports-1:0]      grant_oh;

   // output register empty or drained this cycle
   assign take = !arb_valid || arb_ready;

   // search starts at the port after the last grant and the index wraps on its own
   always_comb begin
      grant_any = 1'b0;
      grant_idx = last_grant;
      grant_oh  = '0;
      cand      = last_grant;
      for (int k = 0; k < flow_cfg_pkg::num_ports; k++) begin
         cand = cand + 1'b1;
         if (!grant_any && s_valid[cand]) begin
            grant_any      = 1'b1;
            grant_idx      = cand;
            grant_oh[cand] = 1'b1;
         end
      end
   end

   assign s_ready = take ? grant_oh : '0;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         arb_valid  <= 1'b0;
         last_grant <= '1;
      end else if (take) begin
         arb_valid <= grant_any;
         if (grant_any) begin
            last_grant <= grant_idx;
         end
      end
   end

   // source port comes from the grant, not from the sender
   always_ff @(posedge axi_aclk) begin
      if (take && grant_any) begin
         arb_hdr.dst_mac  <= s_hdr[grant_idx].dst_mac;
         arb_hdr.src_port <= grant_idx;
      end
   end

endmodule

`default_nettype wire

// File: common/flow_types_pkg.sv
// header, action, table entry and lookup result formats of the flow path
`default_nettype none

package flow_types_pkg;

   // parsed header from an ingress port
   typedef struct packed {
      logic [flow_cfg_pkg::mac_width-1:0]      dst_mac;
      logic [flow_cfg_pkg::port_idx_width-1:0] src_port;
   } hdr_t;

   // ternary entry, a mask bit of 1 means the key bit is compared
   typedef struct packed {
      logic                                    valid;
      logic [flow_cfg_pkg::mac_width-1:0]      key;
      logic [flow_cfg_pkg::mac_width-1:0]      mask;
      logic [flow_cfg_pkg::port_idx_width-1:0] port;
   } tbl_entry_t;

   // header plus its lookup result
   typedef struct packed {
      logic [flow_cfg_pkg::mac_width-1:0]      dst_mac;
      logic [flow_cfg_pkg::port_idx_width-1:0] src_port;
      logic                                    hit;
      logic [flow_cfg_pkg::port_idx_width-1:0] dst_port;
   } lookup_t;

   // action handed to an egress queue
   typedef struct packed {
      logic                                    hit;
      logic                                    miss;
      logic [flow_cfg_pkg::port_idx_width-1:0] src_port;
      logic [flow_cfg_pkg::mac_width-1:0]      dst_mac;
   } act_t;

endpackage

`default_nettype wire

// File: common/flow_cfg_pkg.sv
// flow table processor sizes, table depth and register map
`default_nettype none

package flow_cfg_pkg;

   // ports, port 0 is the host path and the miss target
   localparam int num_ports      = 4;
   localparam int port_idx_width = 2;
   localparam int mac_width      = 48;

   // entries per table bank
   localparam int tbl_depth      = 8;
   localparam int tbl_addr_width = 3;

   // wishbone register bus
   localparam int wb_data_width  = 32;
   localparam int wb_addr_width  = 4;

   // register word addresses
   localparam logic [wb_addr_width-1:0] reg_entry_idx  = 4'd0;
   localparam logic [wb_addr_width-1:0] reg_key_lo     = 4'd1;
   localparam logic [wb_addr_width-1:0] reg_key_hi     = 4'd2;
   localparam logic [wb_addr_width-1:0] reg_mask_lo    = 4'd3;
   localparam logic [wb_addr_width-1:0] reg_mask_hi    = 4'd4;
   localparam logic [wb_addr_width-1:0] reg_action     = 4'd5;
   localparam logic [wb_addr_width-1:0] reg_commit     = 4'd6;
   localparam logic [wb_addr_width-1:0] reg_swap       = 4'd7;
   localparam logic [wb_addr_width-1:0] reg_hit_count  = 4'd8;
   localparam logic [wb_addr_width-1:0] reg_miss_count = 4'd9;
   localparam logic [wb_addr_width-1:0] reg_status     = 4'd10;

endpackage

`default_nettype wire
